/* cpuIsaPkg.sv */
package cpuIsaPkg;

  // major opcode, bits 31:26
  typedef enum logic [5:0] {
    opRtype = 6'd0,   // register-register, funct picks the op
    opXori  = 6'd1,
    opSubi  = 6'd2,
    opAddi  = 6'd3,
    opOri   = 6'd12,
    opAndi  = 6'd15,
    opLoad  = 6'd30,  // lw rt, imm(rs)
    opStore = 6'd31   // sw rt, imm(rs)
  } opcode_t;

  // funct field for opRtype, bits 5:0
  typedef enum logic [5:0] {
    fnXor = 6'd1,
    fnSub = 6'd2,
    fnAdd = 6'd3,
    fnOr  = 6'd4,
    fnAnd = 6'd7
  } funct_t;

  // field positions, lsb plus width
  localparam int OPCODE_LSB   = 26;
  localparam int OPCODE_WIDTH = 6;
  localparam int RS_LSB       = 21;  // first source
  localparam int RS_WIDTH     = 5;
  localparam int RT_LSB       = 16;  // second source, or dest for immediates
  localparam int RT_WIDTH     = 5;
  localparam int RD_LSB       = 11;  // dest for R-type
  localparam int RD_WIDTH     = 5;
  localparam int FUNCT_LSB    = 0;
  localparam int FUNCT_WIDTH  = 6;

  // immediate sits in the low half, sign-extended to a word
  localparam int IMM_LSB      = 0;
  localparam int IMM_WIDTH    = 16;

endpackage

/* cpuPipePkg.sv */
package cpuPipePkg;

  localparam int WORD_WIDTH    = 32;
  localparam int REG_COUNT     = 32;
  localparam int REG_IDX_WIDTH = $clog2(REG_COUNT);  // 5

  typedef logic [WORD_WIDTH-1:0]    word_t;
  typedef logic [REG_IDX_WIDTH-1:0] regIdx_t;

  // what the execute stage does with its operands
  typedef enum logic [2:0] {
    aluXor,
    aluAdd,
    aluSub,  // b inverted, carry-in set
    aluOr,
    aluAnd
  } aluOp_t;

  // memory-stage bus action
  typedef enum logic [1:0] {
    memNone,
    memLoad,   // dataRd strobe, result from dataRdData
    memStore   // dataWr strobe, rt value on dataWrData
  } memOp_t;

  // R-type with funct 0, no write and no bus cycle
  localparam word_t NOP_INSTR = '0;

endpackage

/* carryLookahead.sv */
`timescale 1ns/10ps

module carryLookahead #(
  parameter int width = 32  // power of two, at least 2
) (
  input  logic [width-1:0] gen,
  input  logic [width-1:0] prop,
  input  logic             carryIn,
  output logic [width-1:0] carry,    // carry into each bit
  output logic             groupGen,
  output logic             groupProp
);

  generate
    if (width == 2) begin : gLeaf
      assign carry[0]  = carryIn;
      assign carry[1]  = gen[0] | (prop[0] & carryIn);
      assign groupGen  = gen[1] | (prop[1] & gen[0]);
      assign groupProp = prop[1] & prop[0];
    end else begin : gTree
      localparam int half = width / 2;
      logic loGen, loProp, hiGen, hiProp;
      logic hiCarryIn;

      carryLookahead #(.width(half)) lo (
        .gen(gen[half-1:0]), .prop(prop[half-1:0]), .carryIn(carryIn),
        .carry(carry[half-1:0]), .groupGen(loGen), .groupProp(loProp)
      );

      // upper half starts from whatever leaves the lower half
      assign hiCarryIn = loGen | (loProp & carryIn);

      carryLookahead #(.width(half)) hi (
        .gen(gen[width-1:half]), .prop(prop[width-1:half]), .carryIn(hiCarryIn),
        .carry(carry[width-1:half]), .groupGen(hiGen), .groupProp(hiProp)
      );

      assign groupGen  = hiGen | (hiProp & loGen);
      assign groupProp = hiProp & loProp;  // whole group passes a carry
    end
  endgenerate

endmodule

/* alu32.sv */
`timescale 1ns/10ps

module alu32 (
  input  cpuPipePkg::word_t  a,
  input  cpuPipePkg::word_t  b,
  input  cpuPipePkg::aluOp_t op,
  output cpuPipePkg::word_t  result
);
  import cpuPipePkg::*;

  logic  isSub;
  word_t bEff;     // b or ~b for subtract
  word_t gen;
  word_t prop;
  word_t carry;
  word_t sum;

  assign isSub = (op == aluSub);
  assign bEff  = isSub ? ~b : b;   // a - b = a + ~b + 1

  // per-bit generate and propagate
  assign gen  = a & bEff;
  assign prop = a ^ bEff;

  carryLookahead #(.width(WORD_WIDTH)) cla (
    .gen(gen),
    .prop(prop),
    .carryIn(isSub),   // the +1 of two's complement
    .carry(carry),
    .groupGen(),       // carry out not needed
    .groupProp()
  );

  assign sum = prop ^ carry;

  always_comb begin
    case (op)
      aluAdd,
      aluSub:  result = sum;
      aluXor:  result = a ^ b;   // logic ops straight from the operands
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      default: result = sum;
    endcase
  end

endmodule

/* instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder (
  input  cpuPipePkg::word_t   instr,
  output cpuPipePkg::regIdx_t rs,
  output cpuPipePkg::regIdx_t rt,
  output cpuPipePkg::regIdx_t dest,
  output cpuPipePkg::word_t   imm,
  output logic                useImm,
  output cpuPipePkg::aluOp_t  aluOp,
  output cpuPipePkg::memOp_t  memOp,
  output logic                regWrite
);
  import cpuIsaPkg::*;
  import cpuPipePkg::*;

  opcode_t opcode;
  funct_t  funct;
  regIdx_t rd;

  // raw field split
  assign opcode = opcode_t'(instr[OPCODE_LSB +: OPCODE_WIDTH]);
  assign funct  = funct_t'(instr[FUNCT_LSB +: FUNCT_WIDTH]);
  assign rs     = instr[RS_LSB +: RS_WIDTH];
  assign rt     = instr[RT_LSB +: RT_WIDTH];
  assign rd     = instr[RD_LSB +: RD_WIDTH];

  // sign extend from bit 15
  assign imm = {{(WORD_WIDTH-IMM_WIDTH){instr[IMM_LSB+IMM_WIDTH-1]}},
                instr[IMM_LSB +: IMM_WIDTH]};

  // immediates write rt, R-type writes rd
  assign dest = useImm ? rt : rd;

  always_comb begin
    useImm   = 1'b1;     // most opcodes take the immediate
    aluOp    = aluAdd;
    memOp    = memNone;
    regWrite = 1'b0;     // unknown codes fall through with no write
    case (opcode)
      opAddi: begin aluOp = aluAdd; regWrite = 1'b1; end
      opSubi: begin aluOp = aluSub; regWrite = 1'b1; end
      opXori: begin aluOp = aluXor; regWrite = 1'b1; end
      opAndi: begin aluOp = aluAnd; regWrite = 1'b1; end
      opOri:  begin aluOp = aluOr;  regWrite = 1'b1; end
      opLoad: begin
        memOp    = memLoad;   // address = rs + imm
        regWrite = 1'b1;
      end
      opStore: begin
        memOp = memStore;     // rt goes out as write data
      end
      opRtype: begin
        useImm = 1'b0;
        regWrite = 1'b1;
        case (funct)
          fnAdd:   aluOp = aluAdd;
          fnSub:   aluOp = aluSub;
          fnXor:   aluOp = aluXor;
          fnAnd:   aluOp = aluAnd;
          fnOr:    aluOp = aluOr;
          default: regWrite = 1'b0;  // nop lands here
        endcase
      end
      default: ;
    endcase
  end

endmodule

/* regFile.sv */
`timescale 1ns/10ps

module regFile (
  input  logic                clk,
  input  logic                reset,
  input  cpuPipePkg::regIdx_t rdIdxA,
  output cpuPipePkg::word_t   rdDataA,
  input  cpuPipePkg::regIdx_t rdIdxB,
  output cpuPipePkg::word_t   rdDataB,
  input  logic                wrEn,
  input  cpuPipePkg::regIdx_t wrIdx,
  input  cpuPipePkg::word_t   wrData
);
  import cpuPipePkg::*;

  word_t regs [1:REG_COUNT-1];  // r0 has no storage

  // read with r0 forced to zero and the write in flight bypassed
  function automatic word_t readPort(regIdx_t idx);
    if (idx == '0)
      return '0;
    else if (wrEn && (wrIdx == idx))
      return wrData;   // write-first
    else
      return regs[idx];
  endfunction

  always_comb rdDataA = readPort(rdIdxA);
  always_comb rdDataB = readPort(rdIdxB);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrIdx != '0)) begin  // writes to r0 dropped
      regs[wrIdx] <= wrData;
    end
  end

endmodule

/* pipeCpu.sv */
`timescale 1ns/10ps

module pipeCpu (
  input  logic              clk,
  input  logic              reset,
  input  cpuPipePkg::word_t instr,
  output cpuPipePkg::word_t dataAddr,
  output logic              dataWr,
  output logic              dataRd,
  output cpuPipePkg::word_t dataWrData,
  input  cpuPipePkg::word_t dataRdData
);
  import cpuPipePkg::*;

  // fetch register
  word_t ifInstr;

  // decode stage
  regIdx_t decRs, decRt, decDest;
  word_t   decImm;
  logic    decUseImm;
  aluOp_t  decAluOp;
  memOp_t  decMemOp;
  logic    decRegWrite;
  word_t   rsData, rtData;

  // execute stage
  word_t   exA, exB, exImm;
  logic    exUseImm;
  aluOp_t  exAluOp;
  memOp_t  exMemOp;
  logic    exRegWrite;
  regIdx_t exDest;
  word_t   aluB, aluResult;

  // memory stage
  word_t   memAddr, memStoreData;
  memOp_t  memStageOp;
  logic    memRegWrite;
  regIdx_t memDest;

  // writeback stage
  word_t   wbAlu, wbLoad, wbData;
  memOp_t  wbMemOp;
  logic    wbRegWrite;
  regIdx_t wbDest;

  always_ff @(posedge clk) begin
    if (reset) ifInstr <= NOP_INSTR;
    else       ifInstr <= instr;   // latched every edge, no stall
  end

  instrDecoder dec (
    .instr(ifInstr), .rs(decRs), .rt(decRt), .dest(decDest), .imm(decImm),
    .useImm(decUseImm), .aluOp(decAluOp), .memOp(decMemOp), .regWrite(decRegWrite)
  );

  // write port fed from writeback, bypass covers same-cycle reads
  regFile rf (
    .clk(clk), .reset(reset),
    .rdIdxA(decRs), .rdDataA(rsData),
    .rdIdxB(decRt), .rdDataB(rtData),
    .wrEn(wbRegWrite), .wrIdx(wbDest), .wrData(wbData)
  );

  // decode to execute, controls cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      exMemOp    <= memNone;
      exRegWrite <= 1'b0;
    end else begin
      exMemOp    <= decMemOp;
      exRegWrite <= decRegWrite;
    end
  end

  always_ff @(posedge clk) begin
    exA      <= rsData;
    exB      <= rtData;
    exImm    <= decImm;
    exUseImm <= decUseImm;
    exAluOp  <= decAluOp;
    exDest   <= decDest;
  end

  assign aluB = exUseImm ? exImm : exB;  // operand mux

  alu32 alu (.a(exA), .b(aluB), .op(exAluOp), .result(aluResult));

  // execute to memory
  always_ff @(posedge clk) begin
    if (reset) begin
      memStageOp  <= memNone;
      memRegWrite <= 1'b0;
    end else begin
      memStageOp  <= exMemOp;
      memRegWrite <= exRegWrite;
    end
  end

  always_ff @(posedge clk) begin
    memAddr      <= aluResult;  // base + imm for lw/sw
    memStoreData <= exB;        // rt value, not the mux output
    memDest      <= exDest;
  end

  // bus drive, one cycle per access
  assign dataAddr   = memAddr;
  assign dataWrData = memStoreData;
  assign dataWr     = (memStageOp == memStore);
  assign dataRd     = (memStageOp == memLoad);

  // memory to writeback
  always_ff @(posedge clk) begin
    if (reset) begin
      wbMemOp    <= memNone;
      wbRegWrite <= 1'b0;
    end else begin
      wbMemOp    <= memStageOp;
      wbRegWrite <= memRegWrite;
    end
  end

  always_ff @(posedge clk) begin
    wbAlu  <= memAddr;
    wbLoad <= dataRdData;  // memory answers in the same cycle
    wbDest <= memDest;
  end

  // loaded word or alu result
  assign wbData = (wbMemOp == memLoad) ? wbLoad : wbAlu;

endmodule

/* pipeCpu_chk.sv */
`timescale 1ns/10ps

module pipeCpu_chk (
  input logic               clk,
  input logic               reset,
  input logic               dataWr,
  input logic               dataRd,
  input cpuPipePkg::memOp_t decMemOp
);
  import cpuPipePkg::*;

  // strobes follow the op decoded two edges back, so never both and none for memNone
  strobeFromDecode: assert property (@(posedge clk) disable iff (reset)
    (dataWr == ($past(decMemOp, 2) == memStore)) &&
    (dataRd == ($past(decMemOp, 2) == memLoad)))
    else $error("bus strobes do not match the memory op decoded two cycles earlier");

  quietInReset: assert property (@(posedge clk)
    reset |=> (!dataWr && !dataRd))  // stage controls cleared by reset
    else $error("bus strobe while reset was applied");

  quietAfterReset: assert property (@(posedge clk)
    $fell(reset) |=> (!dataWr && !dataRd))
    else $error("bus strobe on the cycle after reset");

endmodule

bind pipeCpu pipeCpu_chk chk0 (
  .clk(clk),
  .reset(reset),
  .dataWr(dataWr),
  .dataRd(dataRd),
  .decMemOp(decMemOp)
);

/* pipeCpu_tb.sv */
`timescale 1ns/10ps

module pipeCpu_tb;
  import cpuIsaPkg::*;
  import cpuPipePkg::*;

  localparam int          CLK_PERIOD = 4;
  localparam int          MAX_ROWS   = 64;
  localparam int          MEM_WORDS  = 256;  // byte addresses 0 .. 'h3ff
  localparam int          DRAIN      = 3;    // slots for the last row to reach the bus
  localparam logic [31:0] RAND_SEED  = 32'h39f6_ff1c;

  logic  clk;
  logic  reset;
  word_t instr;
  word_t dataAddr;
  logic  dataWr;
  logic  dataRd;
  word_t dataWrData;
  word_t dataRdData;

  // program table, expected columns filled in by the model
  word_t progInstr [MAX_ROWS];
  logic  expStore  [MAX_ROWS];
  logic  expLoad   [MAX_ROWS];
  word_t expAddr   [MAX_ROWS];
  word_t expData   [MAX_ROWS];
  int    progLen;

  word_t mem       [MEM_WORDS];  // memory the DUT talks to
  word_t modelMem  [MEM_WORDS];  // model's own copy
  word_t modelRegs [REG_COUNT];

  int storeRowQ [$];  // rows of expected stores, row order

  int   errorCount;
  logic tableReady;

  pipeCpu dut0 (
    .clk(clk), .reset(reset), .instr(instr),
    .dataAddr(dataAddr), .dataWr(dataWr), .dataRd(dataRd),
    .dataWrData(dataWrData), .dataRdData(dataRdData)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic checkWord(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      errorCount++;
    end
  endtask

  // I-type layout: opcode, rs, rt, 16-bit immediate
  function automatic word_t encImm(opcode_t op, int rs, int rt, int imm);
    word_t w;
    w = '0;
    w[OPCODE_LSB +: OPCODE_WIDTH] = op;
    w[RS_LSB +: RS_WIDTH]         = rs[RS_WIDTH-1:0];
    w[RT_LSB +: RT_WIDTH]         = rt[RT_WIDTH-1:0];
    w[IMM_LSB +: IMM_WIDTH]       = imm[IMM_WIDTH-1:0];  // negative values wrap
    return w;
  endfunction

  function automatic word_t encReg(funct_t fn, int rs, int rt, int rd);
    word_t w;
    w = '0;
    w[OPCODE_LSB +: OPCODE_WIDTH] = opRtype;
    w[RS_LSB +: RS_WIDTH]         = rs[RS_WIDTH-1:0];
    w[RT_LSB +: RT_WIDTH]         = rt[RT_WIDTH-1:0];
    w[RD_LSB +: RD_WIDTH]         = rd[RD_WIDTH-1:0];
    w[FUNCT_LSB +: FUNCT_WIDTH]   = fn;
    return w;
  endfunction

  task automatic addRow(word_t w);
    progInstr[progLen] = w;
    progLen++;
  endtask

  // two slots so that a dependent row sees the result through the bypass
  task automatic addGap();
    addRow(NOP_INSTR);
    addRow(NOP_INSTR);
  endtask

  task automatic buildProgram();
    addRow(encImm(opAddi, 0, 1, 100));
    addRow(encImm(opAddi, 0, 2, -5));
    addRow(encImm(opSubi, 0, 3, 7));
    addRow(encImm(opSubi, 0, 4, -300));  // 0 - (-300)
    addGap();
    for (int r = 1; r <= 4; r++)
      addRow(encImm(opStore, 0, r, 'h100 + 4 * (r - 1)));
    addRow(encReg(fnAdd, 1, 2, 5));
    addRow(encReg(fnSub, 0, 1, 6));      // borrow through every bit
    addRow(encReg(fnSub, 2, 4, 7));
    addRow(encReg(fnXor, 1, 2, 8));
    addRow(encReg(fnAnd, 2, 4, 9));
    addRow(encReg(fnOr, 1, 3, 10));
    addRow(encReg(fnSub, 1, 1, 11));     // carry out of every bit, result zero
    addRow(encReg(fnSub, 4, 3, 12));
    addGap();
    for (int r = 5; r <= 12; r++)
      addRow(encImm(opStore, 0, r, 'h110 + 4 * (r - 5)));
    // immediate bit 15 set, upper half from sign extension
    addRow(encImm(opXori, 1, 13, 'h8001));
    addRow(encImm(opAndi, 2, 14, 'hf0f0));
    addRow(encImm(opOri, 0, 15, 'h8000));
    addGap();
    for (int r = 13; r <= 15; r++)
      addRow(encImm(opStore, 0, r, 'h130 + 4 * (r - 13)));
    addRow(encImm(opLoad, 0, 16, 'h40));   // random word
    addRow(encImm(opLoad, 1, 17, 'h3c));   // base r1, address 'ha0
    addRow(encImm(opLoad, 0, 18, 'h100));  // word stored earlier from r1
    addGap();
    for (int r = 16; r <= 18; r++)
      addRow(encImm(opStore, 0, r, 'h200 + 4 * (r - 16)));
    addRow(encImm(opAddi, 1, 0, 55));      // r0 stays zero
    addGap();
    addRow(encImm(opStore, 0, 0, 'h20c));
    addRow(encReg(fnAdd, 1, 1, 0));
    addGap();
    addRow(encImm(opStore, 0, 0, 'h210));
  endtask

  // widen to a word keeping the sign
  function automatic word_t signExt(logic [IMM_WIDTH-1:0] v);
    logic signed [IMM_WIDTH-1:0] s;
    s = v;
    return WORD_WIDTH'(s);
  endfunction

  function automatic word_t rtypeResult(funct_t fn, word_t a, word_t b);
    case (fn)
      fnAdd:   return a + b;
      fnSub:   return a - b;
      fnXor:   return a ^ b;
      fnAnd:   return a & b;
      fnOr:    return a | b;
      default: return '0;
    endcase
  endfunction

  // walks the table in issue order, one architectural step per row
  task automatic runModel();
    opcode_t op;
    funct_t  fn;
    regIdx_t rs, rt, rd, dst;
    word_t   a, b, imm, addr, res;
    logic    wrReg;
    for (int r = 0; r < REG_COUNT; r++)
      modelRegs[r] = '0;
    for (int i = 0; i < MEM_WORDS; i++)
      modelMem[i] = mem[i];
    for (int i = 0; i < progLen; i++) begin
      op   = opcode_t'(progInstr[i][OPCODE_LSB +: OPCODE_WIDTH]);
      fn   = funct_t'(progInstr[i][FUNCT_LSB +: FUNCT_WIDTH]);
      rs   = progInstr[i][RS_LSB +: RS_WIDTH];
      rt   = progInstr[i][RT_LSB +: RT_WIDTH];
      rd   = progInstr[i][RD_LSB +: RD_WIDTH];
      a    = modelRegs[rs];
      b    = modelRegs[rt];
      imm  = signExt(progInstr[i][IMM_LSB +: IMM_WIDTH]);
      addr = a + imm;
      dst  = (op == opRtype) ? rd : rt;
      case (op)
        opAddi:  res = a + imm;
        opSubi:  res = a - imm;
        opXori:  res = a ^ imm;
        opAndi:  res = a & imm;
        opOri:   res = a | imm;
        opLoad:  res = modelMem[addr[9:2]];
        opRtype: res = rtypeResult(fn, a, b);
        default: res = '0;
      endcase
      wrReg = (op inside {opAddi, opSubi, opXori, opAndi, opOri, opLoad}) ||
              (op == opRtype && (fn inside {fnAdd, fnSub, fnXor, fnAnd, fnOr}));
      expStore[i] = (op == opStore);
      expLoad[i]  = (op == opLoad);
      expAddr[i]  = addr;
      expData[i]  = b;
      if (op == opStore) begin
        modelMem[addr[9:2]] = b;
        storeRowQ.push_back(i);
      end
      if (wrReg && dst != '0)
        modelRegs[dst] = res;
    end
  endtask

  // one falling edge: check strobes, play the memory, set up read data
  task automatic serviceBus(int slot);
    int row;
    int storeRow;
    row = slot - 3;  // row sitting in the memory stage now
    checkFlag("dataWr", dataWr, (row >= 0) ? expStore[row] : 1'b0);
    checkFlag("dataRd", dataRd, (row >= 0) ? expLoad[row] : 1'b0);
    if (dataWr === 1'b1) begin
      if (storeRowQ.size() == 0) begin
        $display("store strobe at %0t with no store left to expect", $time);
        errorCount++;
      end else begin
        storeRow = storeRowQ.pop_front();
        checkWord("dataAddr", dataAddr, expAddr[storeRow]);
        checkWord("dataWrData", dataWrData, expData[storeRow]);
      end
      mem[dataAddr[9:2]] = dataWrData;
    end
    if (dataRd === 1'b1 && row >= 0)
      checkWord("dataAddr", dataAddr, expAddr[row]);
    dataRdData = mem[dataAddr[9:2]];  // captured at the next rising edge
  endtask

  initial begin
    errorCount = 0;
    progLen    = 0;
    tableReady = 1'b0;
    reset      = 1'b1;
    instr      = NOP_INSTR;
    dataRdData = '0;
    void'($urandom(RAND_SEED));
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = $urandom;
    buildProgram();
    runModel();
    tableReady = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int j = 0; j < progLen + DRAIN; j++) begin
      if (j > 0)
        @(negedge clk);
      serviceBus(j);
      instr = (j < progLen) ? progInstr[j] : NOP_INSTR;
    end
    if (storeRowQ.size() != 0) begin
      $display("%0d expected stores never reached the bus", storeRowQ.size());
      errorCount++;
    end
    $display("run finished with %0d errors", errorCount);
    if (errorCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog, program length plus slack
  initial begin
    wait (tableReady);
    #((progLen + 20) * CLK_PERIOD);
    $display("timeout after %0d cycles, the program did not finish", progLen + 20);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* sources.f */
cpuIsaPkg.sv
cpuPipePkg.sv
carryLookahead.sv
alu32.sv
instrDecoder.sv
regFile.sv
pipeCpu.sv
pipeCpu_chk.sv
pipeCpu_tb.sv

/* runSim.sh */
#!/bin/sh
# build with Verilator, run, and grade the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module pipeCpu_tb -f sources.f \
  -o pipeCpuSim > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/pipeCpuSim > sim.log 2>&1 \
  || { cat sim.log; echo "simulation exited with an error status"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation reported no failure"
exit 0
